// File: logic/fetch_cfg_pkg.sv
// frontend configuration constants: widths, queue depth, credit sizing, boot address, fetch step
`default_nettype none

package fetch_cfg_pkg;

    // --------------------------------------------------------------------------
    // datapath widths
    // --------------------------------------------------------------------------
    // byte address of a fetch
    localparam int unsigned ADDR_W = 32;
    // one RV32 instruction word
    localparam int unsigned INSTR_W = 32;

    // --------------------------------------------------------------------------
    // credit loop sizing
    // --------------------------------------------------------------------------
    // queue entries toward the back-end, also the credits pc_gen starts with
    localparam int unsigned QUEUE_DEPTH = 4;
    // has to hold 0 up to QUEUE_DEPTH inclusive
    localparam int unsigned CREDIT_W = $clog2(QUEUE_DEPTH + 1);
    // ring index, depth is a power of two so pointers wrap on their own
    localparam int unsigned QPTR_W = $clog2(QUEUE_DEPTH);

    // --------------------------------------------------------------------------
    // program counter
    // --------------------------------------------------------------------------
    // first fetch address out of reset
    localparam logic [ADDR_W-1:0] BOOT_ADDR = ADDR_W'(32'h0000_1000);
    // no compressed instructions, every step is a full word
    localparam logic [ADDR_W-1:0] INSTR_BYTES = ADDR_W'(4);

endpackage

`default_nettype wire

// File: logic/rv_instr_pkg.sv
// RISC-V major opcode enum, control-flow class enum and predecode field positions
`default_nettype none

package rv_instr_pkg;

    // opcode field sits in the low seven bits
    localparam int unsigned OPCODE_LSB = 0;
    localparam int unsigned OPCODE_MSB = 6;
    // sign of every immediate, so also the static prediction bit
    localparam int unsigned SIGN_BIT = 31;

    // major opcodes that predecode tells apart, ISA encodings
    typedef enum logic [6:0] {
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        // loads, stores, alu, system: all the same to the frontend
        OTHER  = 7'b0000000
    } opcode_e;

    // control-flow class carried with each entry
    typedef enum logic [2:0] {
        NO_CF,
        BRANCH_TAKEN,
        BRANCH_NOT_TAKEN,
        JUMP,
        // target lives in a register, left to the back-end
        JUMP_REG
    } cf_e;

endpackage

`default_nettype wire

// File: logic/pc_gen.sv
// program counter register, next-PC selection, credit counter and fetch request issue
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // back-end control change, one cycle pulse
    input  logic                               redirect_i,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0]   redirect_pc_i,
    // static prediction from branch_scan
    input  logic                               bp_redirect_i,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0]   bp_target_i,
    // credit returns from the later stages
    input  logic                               resp_credit_i,
    input  logic                               scan_credit_i,
    input  logic [fetch_cfg_pkg::CREDIT_W-1:0] queue_credit_cnt_i,
    // instruction memory request, always accepted
    output logic                               imem_req_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]   imem_addr_o
);
    import fetch_cfg_pkg::*;

    logic [ADDR_W-1:0]   pc_q;
    logic [ADDR_W-1:0]   pc_d;
    logic [CREDIT_W-1:0] credit_q;
    logic [CREDIT_W-1:0] credit_d;
    // low during reset, first request goes out right after
    logic                active_q;

    // --------------------------------------------------------------------------
    // request issue
    // --------------------------------------------------------------------------
    // a redirect cycle issues nothing, the new target goes out next cycle
    assign imem_req_o  = active_q && (credit_q != '0) && !redirect_i && !bp_redirect_i;
    assign imem_addr_o = pc_q;

    // --------------------------------------------------------------------------
    // next PC
    // --------------------------------------------------------------------------
    always_comb begin : next_pc
        pc_d = pc_q;
        // back-end beats the static prediction
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (bp_redirect_i) begin
            pc_d = bp_target_i;
        end else if (imem_req_o) begin
            pc_d = pc_q + INSTR_BYTES;
        end
    end

    // one credit out per request, returns from three places
    assign credit_d = credit_q
                    - CREDIT_W'(imem_req_o)
                    + CREDIT_W'(resp_credit_i)
                    + CREDIT_W'(scan_credit_i)
                    + queue_credit_cnt_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            pc_q     <= BOOT_ADDR;
            credit_q <= CREDIT_W'(QUEUE_DEPTH);
        end else begin
            active_q <= 1'b1;
            pc_q     <= pc_d;
            credit_q <= credit_d;
        end
    end

    // every stage returns each credit exactly once, so the pool stays bounded
    a_credit_bound : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        credit_q <= CREDIT_W'(QUEUE_DEPTH)
    ) else $error("pc_gen: credit count %0d above queue depth", credit_q);

endmodule

`default_nettype wire

// File: logic/fetch_resp.sv
// in-flight address FIFO, response discard after redirects and the response register
`timescale 1ns/1ps
`default_nettype none

module fetch_resp (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // request as issued by pc_gen
    input  logic                              imem_req_i,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0]  imem_addr_i,
    // in-order memory responses
    input  logic                              imem_rsp_valid_i,
    input  logic [fetch_cfg_pkg::INSTR_W-1:0] imem_rsp_data_i,
    input  logic                              redirect_i,
    input  logic                              bp_redirect_i,
    output logic                              rsp_valid_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]  rsp_pc_o,
    output logic [fetch_cfg_pkg::INSTR_W-1:0] rsp_instr_o,
    output logic                              resp_credit_o
);
    import fetch_cfg_pkg::*;

    // PCs of outstanding requests, credits keep this from overflowing
    logic [ADDR_W-1:0]   addr_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   wr_ptr_q;
    logic [QPTR_W-1:0]   rd_ptr_q;
    logic [CREDIT_W-1:0] inflight_q;
    // responses still owed to the old path
    logic [CREDIT_W-1:0] discard_q;
    logic                kill;
    logic                drop;

    assign kill = redirect_i || bp_redirect_i;
    // the response arriving in the redirect cycle is old as well
    assign drop = imem_rsp_valid_i && (kill || (discard_q != '0));
    // dropped word hands its credit straight back
    assign resp_credit_o = drop;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            inflight_q  <= '0;
            discard_q   <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            wr_ptr_q   <= wr_ptr_q + QPTR_W'(imem_req_i);
            rd_ptr_q   <= rd_ptr_q + QPTR_W'(imem_rsp_valid_i);
            inflight_q <= inflight_q + CREDIT_W'(imem_req_i) - CREDIT_W'(imem_rsp_valid_i);
            if (kill) begin
                // everything outstanding predates the redirect
                discard_q <= inflight_q - CREDIT_W'(imem_rsp_valid_i);
            end else if (drop) begin
                discard_q <= discard_q - CREDIT_W'(1);
            end
            // also clears a held response on redirect
            rsp_valid_o <= imem_rsp_valid_i && !drop;
        end
    end

    // address ring and response payload
    always_ff @(posedge clk_i) begin
        if (imem_req_i) begin
            addr_mem[wr_ptr_q] <= imem_addr_i;
        end
        if (imem_rsp_valid_i) begin
            rsp_pc_o    <= addr_mem[rd_ptr_q];
            rsp_instr_o <= imem_rsp_data_i;
        end
    end

    a_rsp_outstanding : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        imem_rsp_valid_i |-> (inflight_q != '0)
    ) else $error("fetch_resp: response with no request outstanding");

endmodule

`default_nettype wire

// File: logic/branch_scan.sv
// predecode, static branch prediction, target calculation and the internal redirect
`timescale 1ns/1ps
`default_nettype none

module branch_scan (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              rsp_valid_i,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0]  rsp_pc_i,
    input  logic [fetch_cfg_pkg::INSTR_W-1:0] rsp_instr_i,
    input  logic                              redirect_i,
    input  logic                              queue_ready_i,
    output logic                              scan_valid_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]  scan_pc_o,
    output logic [fetch_cfg_pkg::INSTR_W-1:0] scan_instr_o,
    output rv_instr_pkg::cf_e                 scan_cf_o,
    // predicted next PC of the entry
    output logic [fetch_cfg_pkg::ADDR_W-1:0]  scan_target_o,
    output logic                              bp_redirect_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]  bp_target_o,
    output logic                              scan_credit_o
);
    import fetch_cfg_pkg::*;
    import rv_instr_pkg::*;

    opcode_e           opcode;
    cf_e               cf;
    logic [ADDR_W-1:0] b_imm;
    logic [ADDR_W-1:0] j_imm;
    logic [ADDR_W-1:0] target;
    logic              taken;
    logic              live;
    logic              advance;

    // --------------------------------------------------------------------------
    // predecode
    // --------------------------------------------------------------------------
    always_comb begin : decode
        case (rsp_instr_i[OPCODE_MSB:OPCODE_LSB])
            BRANCH:  opcode = BRANCH;
            JAL:     opcode = JAL;
            JALR:    opcode = JALR;
            default: opcode = OTHER;
        endcase
    end

    // B and J immediates, bit 0 is always zero
    assign b_imm = {{(ADDR_W - 12){rsp_instr_i[SIGN_BIT]}}, rsp_instr_i[7],
                    rsp_instr_i[30:25], rsp_instr_i[11:8], 1'b0};
    assign j_imm = {{(ADDR_W - 20){rsp_instr_i[SIGN_BIT]}}, rsp_instr_i[19:12],
                    rsp_instr_i[20], rsp_instr_i[30:21], 1'b0};

    // static rule: backward branch taken, JAL taken, all else falls through
    always_comb begin : classify
        cf     = NO_CF;
        target = rsp_pc_i + INSTR_BYTES;
        case (opcode)
            BRANCH: begin
                cf = BRANCH_NOT_TAKEN;
                if (rsp_instr_i[SIGN_BIT]) begin
                    cf     = BRANCH_TAKEN;
                    target = rsp_pc_i + b_imm;
                end
            end
            JAL: begin
                cf     = JUMP;
                target = rsp_pc_i + j_imm;
            end
            // register target unknown here, keep going sequentially
            JALR:    cf = JUMP_REG;
            default: cf = NO_CF;
        endcase
    end

    assign taken = (cf == BRANCH_TAKEN) || (cf == JUMP);

    // --------------------------------------------------------------------------
    // stage register and kill
    // --------------------------------------------------------------------------
    // input is younger than either redirect, so it dies with it
    assign live          = rsp_valid_i && !redirect_i && !bp_redirect_o;
    assign scan_credit_o = rsp_valid_i && !live;
    // queue holds only what credits allow, so this stays high in practice
    assign advance       = !scan_valid_o || queue_ready_i;
    assign bp_target_o   = scan_target_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            scan_valid_o  <= 1'b0;
            bp_redirect_o <= 1'b0;
        end else if (redirect_i) begin
            // the queue returns the credit of the entry sitting here
            scan_valid_o  <= 1'b0;
            bp_redirect_o <= 1'b0;
        end else if (advance) begin
            scan_valid_o  <= live;
            bp_redirect_o <= live && taken;
        end else begin
            bp_redirect_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance && live) begin
            scan_pc_o     <= rsp_pc_i;
            scan_instr_o  <= rsp_instr_i;
            scan_cf_o     <= cf;
            scan_target_o <= target;
        end
    end

endmodule

`default_nettype wire

// File: logic/instr_queue.sv
// fetch entry FIFO toward the back-end with valid/ready output and credit return
`timescale 1ns/1ps
`default_nettype none

module instr_queue (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               scan_valid_i,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0]   scan_pc_i,
    input  logic [fetch_cfg_pkg::INSTR_W-1:0]  scan_instr_i,
    input  rv_instr_pkg::cf_e                  scan_cf_i,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0]   scan_target_i,
    input  logic                               redirect_i,
    input  logic                               entry_ready_i,
    output logic                               queue_ready_o,
    // back-end side
    output logic                               entry_valid_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]   entry_pc_o,
    output logic [fetch_cfg_pkg::INSTR_W-1:0]  entry_instr_o,
    output rv_instr_pkg::cf_e                  entry_cf_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]   entry_target_o,
    output logic [fetch_cfg_pkg::CREDIT_W-1:0] queue_credit_cnt_o
);
    import fetch_cfg_pkg::*;
    import rv_instr_pkg::*;

    // entry storage
    logic [ADDR_W-1:0]   pc_mem     [QUEUE_DEPTH];
    logic [INSTR_W-1:0]  instr_mem  [QUEUE_DEPTH];
    cf_e                 cf_mem     [QUEUE_DEPTH];
    logic [ADDR_W-1:0]   target_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   wr_ptr_q;
    logic [QPTR_W-1:0]   rd_ptr_q;
    logic [CREDIT_W-1:0] count_q;
    logic                full;
    logic                push;
    logic                pop;

    assign full          = (count_q == CREDIT_W'(QUEUE_DEPTH));
    assign queue_ready_o = !full;
    // entries arriving with a redirect are old path
    assign push          = scan_valid_i && !full && !redirect_i;
    assign entry_valid_o = (count_q != '0);
    assign pop           = entry_valid_o && entry_ready_i;

    // head is read straight from storage, visible the cycle after the write
    assign entry_pc_o     = pc_mem[rd_ptr_q];
    assign entry_instr_o  = instr_mem[rd_ptr_q];
    assign entry_cf_o     = cf_mem[rd_ptr_q];
    assign entry_target_o = target_mem[rd_ptr_q];

    // flush hands back the occupancy plus the refused incoming entry
    assign queue_credit_cnt_o = redirect_i ? count_q + CREDIT_W'(scan_valid_i)
                                           : CREDIT_W'(pop);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (redirect_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + QPTR_W'(push);
            rd_ptr_q <= rd_ptr_q + QPTR_W'(pop);
            count_q  <= count_q + CREDIT_W'(push) - CREDIT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_mem[wr_ptr_q]     <= scan_pc_i;
            instr_mem[wr_ptr_q]  <= scan_instr_i;
            cf_mem[wr_ptr_q]     <= scan_cf_i;
            target_mem[wr_ptr_q] <= scan_target_i;
        end
    end

    // credits in pc_gen must keep the upstream from ever meeting a full queue
    a_no_write_full : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        scan_valid_i |-> !full
    ) else $error("instr_queue: write while full");

endmodule

`default_nettype wire

// File: logic/fetch_frontend.sv
// frontend top level: pc_gen, fetch_resp, branch_scan and instr_queue in a chain
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // instruction memory
    output logic                              imem_req_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]  imem_addr_o,
    input  logic                              imem_rsp_valid_i,
    input  logic [fetch_cfg_pkg::INSTR_W-1:0] imem_rsp_data_i,
    // back-end control change
    input  logic                              redirect_i,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0]  redirect_pc_i,
    // fetch entries to the back-end
    output logic                              entry_valid_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]  entry_pc_o,
    output logic [fetch_cfg_pkg::INSTR_W-1:0] entry_instr_o,
    output rv_instr_pkg::cf_e                 entry_cf_o,
    output logic [fetch_cfg_pkg::ADDR_W-1:0]  entry_target_o,
    input  logic                              entry_ready_i
);
    import fetch_cfg_pkg::*;
    import rv_instr_pkg::*;

    // internal redirect and credit loop
    logic                bp_redirect;
    logic [ADDR_W-1:0]   bp_target;
    logic                resp_credit;
    logic                scan_credit;
    logic [CREDIT_W-1:0] queue_credit_cnt;
    // stage 2 to 3
    logic                rsp_valid;
    logic [ADDR_W-1:0]   rsp_pc;
    logic [INSTR_W-1:0]  rsp_instr;
    // stage 3 to 4
    logic                scan_valid;
    logic [ADDR_W-1:0]   scan_pc;
    logic [INSTR_W-1:0]  scan_instr;
    cf_e                 scan_cf;
    logic [ADDR_W-1:0]   scan_target;
    logic                queue_ready;

    pc_gen pc_gen_inst (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .redirect_i         (redirect_i),
        .redirect_pc_i      (redirect_pc_i),
        .bp_redirect_i      (bp_redirect),
        .bp_target_i        (bp_target),
        .resp_credit_i      (resp_credit),
        .scan_credit_i      (scan_credit),
        .queue_credit_cnt_i (queue_credit_cnt),
        .imem_req_o         (imem_req_o),
        .imem_addr_o        (imem_addr_o)
    );

    fetch_resp fetch_resp_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .imem_req_i       (imem_req_o),
        .imem_addr_i      (imem_addr_o),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_rsp_data_i  (imem_rsp_data_i),
        .redirect_i       (redirect_i),
        .bp_redirect_i    (bp_redirect),
        .rsp_valid_o      (rsp_valid),
        .rsp_pc_o         (rsp_pc),
        .rsp_instr_o      (rsp_instr),
        .resp_credit_o    (resp_credit)
    );

    branch_scan branch_scan_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .rsp_valid_i   (rsp_valid),
        .rsp_pc_i      (rsp_pc),
        .rsp_instr_i   (rsp_instr),
        .redirect_i    (redirect_i),
        .queue_ready_i (queue_ready),
        .scan_valid_o  (scan_valid),
        .scan_pc_o     (scan_pc),
        .scan_instr_o  (scan_instr),
        .scan_cf_o     (scan_cf),
        .scan_target_o (scan_target),
        .bp_redirect_o (bp_redirect),
        .bp_target_o   (bp_target),
        .scan_credit_o (scan_credit)
    );

    instr_queue instr_queue_inst (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .scan_valid_i       (scan_valid),
        .scan_pc_i          (scan_pc),
        .scan_instr_i       (scan_instr),
        .scan_cf_i          (scan_cf),
        .scan_target_i      (scan_target),
        .redirect_i         (redirect_i),
        .entry_ready_i      (entry_ready_i),
        .queue_ready_o      (queue_ready),
        .entry_valid_o      (entry_valid_o),
        .entry_pc_o         (entry_pc_o),
        .entry_instr_o      (entry_instr_o),
        .entry_cf_o         (entry_cf_o),
        .entry_target_o     (entry_target_o),
        .queue_credit_cnt_o (queue_credit_cnt)
    );

endmodule

`default_nettype wire

// File: test/fetch_ref.svh
// instruction image of the test program and the reference static next-PC rule
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// beq x0, x0 with a signed byte offset
function automatic logic [31:0] enc_branch(input int off);
    logic [31:0] o;
    o = off;
    enc_branch = {o[12], o[10:5], 5'd0, 5'd0, 3'b000, o[4:1], o[11], 7'b1100011};
endfunction

// jal x0 with a signed byte offset
function automatic logic [31:0] enc_jal(input int off);
    logic [31:0] o;
    o = off;
    enc_jal = {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
endfunction

// ----------------------------------------------------------------------------
// program image
// ----------------------------------------------------------------------------
// 0x1000..0x100c straight, 0x1010 forward branch, 0x1018 back to 0x0ffc,
// 0x0ffc jal to 0x1100, 0x1110 jal back to 0x1000
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    case (addr)
        32'h0000_0ffc: mem_word = enc_jal(260);
        32'h0000_1010: mem_word = enc_branch(32);
        32'h0000_1018: mem_word = enc_branch(-28);
        32'h0000_1110: mem_word = enc_jal(-272);
        // op-imm filler, every address bit folded in
        default:       mem_word = {addr[31:7] ^ addr[24:0], 7'b0010011};
    endcase
endfunction

// expected class and next PC
function automatic logic [31:0] ref_next(input logic [31:0] pc, input logic [31:0] instr,
                                         output cf_e cf);
    logic [31:0] b_off;
    logic [31:0] j_off;
    b_off = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    j_off = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    cf = NO_CF;
    ref_next = pc + 32'd4;
    case (instr[6:0])
        7'b1100011: begin
            // backward means taken
            if ($signed(b_off) < 0) begin
                cf = BRANCH_TAKEN;
                ref_next = pc + b_off;
            end else begin
                cf = BRANCH_NOT_TAKEN;
            end
        end
        7'b1101111: begin
            cf = JUMP;
            ref_next = pc + j_off;
        end
        7'b1100111: cf = JUMP_REG;
        default:    cf = NO_CF;
    endcase
endfunction

`endif

// File: test/tb_fetch_frontend.sv
// testbench for the fetch frontend: clock, reset, memory model, stimulus, comparison, reporting
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;
    import fetch_cfg_pkg::*;
    import rv_instr_pkg::*;

    `include "fetch_ref.svh"

    localparam int RST_CYCLES     = 10;
    localparam int TOTAL_ENTRIES  = 4 + 3 + 7 + 8 + 24;
    // worst case per entry under 1/3 ready and 4 cycle latency, plus slack
    localparam int TIMEOUT_CYCLES = RST_CYCLES + TOTAL_ENTRIES * 25 + 50;
    localparam logic [ADDR_W-1:0] JUMP_PC = 32'h0000_2000;

    logic                clk_i = 1'b0;
    logic                rst_ni;
    logic                imem_req_o;
    logic [ADDR_W-1:0]   imem_addr_o;
    logic                imem_rsp_valid_i;
    logic [INSTR_W-1:0]  imem_rsp_data_i;
    logic                redirect_i;
    logic [ADDR_W-1:0]   redirect_pc_i;
    logic                entry_valid_o;
    logic [ADDR_W-1:0]   entry_pc_o;
    logic [INSTR_W-1:0]  entry_instr_o;
    cf_e                 entry_cf_o;
    logic [ADDR_W-1:0]   entry_target_o;
    logic                entry_ready_i;

    integer              seed = 32;
    int                  cycle_cnt = 0;
    int                  checked_cnt = 0;
    int                  err_cnt = 0;
    // requests and pops seen since the redirect, for the credit bound
    int                  issued_cnt = 0;
    int                  popped_cnt = 0;
    logic                bound_en = 1'b0;
    logic [ADDR_W-1:0]   exp_pc = BOOT_ADDR;
    // memory model: address and due cycle of each pending request
    logic [ADDR_W-1:0]   pend_addr [$];
    int                  pend_due [$];
    int                  last_due = 0;

    fetch_frontend fetch_frontend_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_rsp_data_i  (imem_rsp_data_i),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .entry_valid_o    (entry_valid_o),
        .entry_pc_o       (entry_pc_o),
        .entry_instr_o    (entry_instr_o),
        .entry_cf_o       (entry_cf_o),
        .entry_target_o   (entry_target_o),
        .entry_ready_i    (entry_ready_i)
    );

    always #5 clk_i = ~clk_i;

    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s exp 0x%08h got 0x%08h", $time, sig, exp, got);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------------------
    // in order, latency 1 to 4, at most one response per cycle
    always @(posedge clk_i) begin : mem_capture
        int due;
        cycle_cnt <= cycle_cnt + 1;
        if (rst_ni && imem_req_o) begin
            due = cycle_cnt + 1 + ($unsigned($random(seed)) % 4);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            pend_addr.push_back(imem_addr_o);
            pend_due.push_back(due);
        end
    end

    initial begin : mem_driver
        imem_rsp_valid_i = 1'b0;
        imem_rsp_data_i  = '0;
        forever begin
            @(negedge clk_i);
            if (pend_addr.size() > 0 && pend_due[0] <= cycle_cnt) begin
                imem_rsp_valid_i = 1'b1;
                imem_rsp_data_i  = mem_word(pend_addr[0]);
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end else begin
                imem_rsp_valid_i = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // comparison
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin : compare
        cf_e               exp_cf;
        logic [ADDR_W-1:0] exp_next;
        if (rst_ni) begin
            if (entry_valid_o && entry_ready_i) begin
                exp_next = ref_next(exp_pc, mem_word(exp_pc), exp_cf);
                check_value("entry_pc_o", entry_pc_o, exp_pc);
                check_value("entry_instr_o", entry_instr_o, mem_word(exp_pc));
                check_value("entry_cf_o", 32'(entry_cf_o), 32'(exp_cf));
                check_value("entry_target_o", entry_target_o, exp_next);
                exp_pc = exp_next;
                checked_cnt++;
                popped_cnt++;
            end
            issued_cnt = issued_cnt + int'(imem_req_o);
            // new path is straight-line, so every credit comes back through a pop
            if (redirect_i) begin
                exp_pc     = redirect_pc_i;
                issued_cnt = 0;
                popped_cnt = 0;
                bound_en   = 1'b1;
            end
            if (bound_en && (issued_cnt - popped_cnt > QUEUE_DEPTH)) begin
                $display("ERR t=%0t requests outstanding exp <= %0d got %0d",
                         $time, QUEUE_DEPTH, issued_cnt - popped_cnt);
                err_cnt++;
            end
        end
    end

    always @(negedge clk_i) begin : watchdog
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: only %0d of %0d entries arrived within %0d cycles",
                     checked_cnt, TOTAL_ENTRIES, TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic run_entries(input int num, input string name, input int n, input bit rnd);
        int target;
        int err_start;
        target    = checked_cnt + n;
        err_start = err_cnt;
        while (checked_cnt < target) begin
            @(negedge clk_i);
            if (rnd) begin
                entry_ready_i = (($unsigned($random(seed)) % 3) == 0);
            end else begin
                entry_ready_i = 1'b1;
            end
        end
        $display("test %0d %s: %0d entries, %0d errors", num, name, n, err_cnt - err_start);
    endtask

    // back-end holds ready low while it redirects
    task automatic pulse_redirect(input logic [ADDR_W-1:0] target);
        @(negedge clk_i);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        entry_ready_i = 1'b0;
        @(negedge clk_i);
        redirect_i    = 1'b0;
    endtask

    initial begin
        rst_ni        = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        entry_ready_i = 1'b0;
        repeat (RST_CYCLES) @(negedge clk_i);
        check_value("imem_req_o", 32'(imem_req_o), 32'd0);
        check_value("entry_valid_o", 32'(entry_valid_o), 32'd0);
        rst_ni = 1'b1;

        run_entries(1, "straight-line fetch", 4, 1'b0);
        run_entries(2, "branches", 3, 1'b0);
        run_entries(3, "jal", 7, 1'b0);
        pulse_redirect(JUMP_PC);
        run_entries(4, "external redirect", 8, 1'b0);
        run_entries(5, "back-pressure", 24, 1'b1);

        $display("done: %0d entries checked, %0d errors", checked_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+test
logic/fetch_cfg_pkg.sv
logic/rv_instr_pkg.sv
logic/pc_gen.sv
logic/fetch_resp.sv
logic/branch_scan.sv
logic/instr_queue.sv
logic/fetch_frontend.sv
test/tb_fetch_frontend.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - logic/fetch_cfg_pkg.sv
      - logic/rv_instr_pkg.sv
      - logic/pc_gen.sv
      - logic/fetch_resp.sv
      - logic/branch_scan.sv
      - logic/instr_queue.sv
      - logic/fetch_frontend.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fetch_frontend.sv
